/* source/z80_exec_pkg.sv */
package z80_exec_pkg;

  // ALU opcodes
  typedef enum logic [4:0] {
    ADD8  = 5'd0,
    SUB8  = 5'd1,
    ADC   = 5'd2,
    SBC   = 5'd3,
    AND   = 5'd4,
    OR    = 5'd5,
    XOR   = 5'd6,
    NOT   = 5'd7,
    ADD16 = 5'd8,
    SUB16 = 5'd9,
    RR    = 5'd10,  // Through carry
    RL    = 5'd11,  // Through carry
    RRC   = 5'd12,
    RLC   = 5'd13,
    SLA   = 5'd14,
    SRA   = 5'd15,
    SLL   = 5'd16,  // Shifts in a 1
    SRL   = 5'd17,
    RES   = 5'd18,
    SET   = 5'd19,
    BIT   = 5'd20
  } alu_op_t;

  // Even index is the high byte of a pair
  typedef enum logic [2:0] {
    REG_B = 3'd0,
    REG_C = 3'd1,
    REG_D = 3'd2,
    REG_E = 3'd3,
    REG_H = 3'd4,
    REG_L = 3'd5,
    REG_W = 3'd6,
    REG_A = 3'd7
  } reg_idx_t;

  typedef enum logic {
    EX_IDLE  = 1'b0,
    EX_WRITE = 1'b1
  } exec_state_t;

  // Flag byte layout, bits 5 and 2 reserved
  localparam int FLAG_S = 7;
  localparam int FLAG_Z = 6;
  localparam int FLAG_H = 4;  // Half carry, always 0
  localparam int FLAG_V = 3;  // Overflow or parity
  localparam int FLAG_N = 1;
  localparam int FLAG_C = 0;

endpackage

/* source/alu.sv */
`timescale 1ns/1ps

module alu
  import z80_exec_pkg::*;
(
  input  logic        cin,
  input  alu_op_t     op,
  input  logic [15:0] x,
  input  logic [15:0] y,
  output logic [7:0]  flags,
  output logic [15:0] result
);

  logic [16:0] sum_diff;  // One extra bit for carry out
  logic [7:0]  bit_mask;
  logic        c_flag;
  logic        s_flag;
  logic        z_flag;
  logic        v_flag;
  logic        n_flag;
  logic        wide;

  assign wide = (op == ADD16) || (op == SUB16);

  // Adder and subtractor
  always_comb begin
    case (op)
      ADD8, ADD16: sum_diff = {1'b0, x} + {1'b0, y};
      SUB8, SUB16: sum_diff = {1'b0, x} - {1'b0, y};
      ADC:         sum_diff = {1'b0, x} + {1'b0, y} + {16'b0, cin};
      SBC:         sum_diff = {1'b0, x} - {1'b0, y} - {16'b0, cin};
      default:     sum_diff = 17'b0;
    endcase
  end

  always_comb begin
    bit_mask = 8'h00;
    bit_mask[y[2:0]] = 1'b1;
    result = 16'b0;
    case (op)
      ADD8, SUB8, ADC, SBC: result[7:0] = sum_diff[7:0];
      ADD16, SUB16:         result      = sum_diff[15:0];
      AND:                  result[7:0] = x[7:0] & y[7:0];
      OR:                   result[7:0] = x[7:0] | y[7:0];
      XOR:                  result[7:0] = x[7:0] ^ y[7:0];
      NOT:                  result[7:0] = ~x[7:0];
      RR:                   result[7:0] = {cin, x[7:1]};
      RL:                   result[7:0] = {x[6:0], cin};
      RRC:                  result[7:0] = {x[0], x[7:1]};
      RLC:                  result[7:0] = {x[6:0], x[7]};
      SLA:                  result[7:0] = {x[6:0], 1'b0};
      SRA:                  result[7:0] = {x[7], x[7:1]};
      SLL:                  result[7:0] = {x[6:0], 1'b1};
      SRL:                  result[7:0] = {1'b0, x[7:1]};
      RES:                  result[7:0] = x[7:0] & ~bit_mask;
      SET:                  result[7:0] = x[7:0] | bit_mask;
      default:              result      = 16'b0;  // BIT has no result
    endcase
  end

  // Carry out, or the bit shifted out
  always_comb begin
    case (op)
      ADD8, SUB8, ADC, SBC:   c_flag = sum_diff[8];
      ADD16, SUB16:           c_flag = sum_diff[16];
      RL, RLC, SLA, SLL:      c_flag = x[7];
      RR, RRC, SRA, SRL:      c_flag = x[0];
      default:                c_flag = 1'b0;
    endcase
  end

  assign s_flag = wide ? result[15] : result[7];

  always_comb begin
    if (wide) begin
      z_flag = (result == 16'b0);
    end else if (op == BIT) begin
      z_flag = ~|(x[7:0] & bit_mask);  // Set when tested bit is 0
    end else begin
      z_flag = (result[7:0] == 8'b0);
    end
  end

  // Signed overflow for arithmetic, even parity for logic and shifts
  always_comb begin
    case (op)
      ADD8, ADC: v_flag = (x[7] == y[7]) && (result[7] != x[7]);
      SUB8, SBC: v_flag = (x[7] != y[7]) && (result[7] != x[7]);
      ADD16:     v_flag = (x[15] == y[15]) && (result[15] != x[15]);
      SUB16:     v_flag = (x[15] != y[15]) && (result[15] != x[15]);
      AND, OR, XOR, SLA, SRA, SLL: v_flag = ~^result[7:0];
      default:   v_flag = 1'b0;
    endcase
  end

  assign n_flag = (op == ADD8) || (op == ADC) || (op == ADD16);

  always_comb begin
    flags         = 8'h00;  // H and reserved bits stay 0
    flags[FLAG_S] = s_flag;
    flags[FLAG_Z] = z_flag;
    flags[FLAG_V] = v_flag;
    flags[FLAG_N] = n_flag;
    flags[FLAG_C] = c_flag;
  end

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file
  import z80_exec_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  reg_idx_t    x_sel,
  input  reg_idx_t    y_sel,
  input  reg_idx_t    dbg_sel,
  input  reg_idx_t    wr_sel,
  input  reg_idx_t    load_sel,
  output logic [7:0]  x_byte,
  output logic [7:0]  y_byte,
  output logic [7:0]  dbg_data,
  output logic [15:0] x_pair,
  output logic [15:0] y_pair,
  input  logic        wr_en,
  input  logic        wr_wide,
  input  logic        load,
  input  logic [15:0] wr_data,
  input  logic [7:0]  load_data
);

  logic [7:0] regs [8];

  // Byte reads
  assign x_byte   = regs[x_sel];
  assign y_byte   = regs[y_sel];
  assign dbg_data = regs[dbg_sel];

  // Pair reads, even register is the high byte
  assign x_pair = {regs[{x_sel[2:1], 1'b0}], regs[{x_sel[2:1], 1'b1}]};
  assign y_pair = {regs[{y_sel[2:1], 1'b0}], regs[{y_sel[2:1], 1'b1}]};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      regs <= '{default: 8'h00};
    end else begin
      if (load) begin
        regs[load_sel] <= load_data;
      end
      // Later assignment so write-back beats a load to the same register
      if (wr_en) begin
        if (wr_wide) begin
          regs[{wr_sel[2:1], 1'b0}] <= wr_data[15:8];
          regs[{wr_sel[2:1], 1'b1}] <= wr_data[7:0];
        end else begin
          regs[wr_sel] <= wr_data[7:0];
        end
      end
    end
  end

endmodule

/* source/flag_reg.sv */
`timescale 1ns/1ps

module flag_reg
  import z80_exec_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       upd,
  input  alu_op_t    op,
  input  logic [7:0] alu_flags,
  output logic [7:0] flags,
  output logic       carry
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags <= 8'h00;
    end else if (upd) begin
      case (op)
        RES, SET: flags <= flags;                         // Bit ops keep flags
        BIT:      flags[FLAG_Z] <= alu_flags[FLAG_Z];     // Only Z moves
        default:  flags <= alu_flags;
      endcase
    end
  end

  // Stored carry feeds ADC, SBC, RR and RL
  assign carry = flags[FLAG_C];

endmodule

/* source/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage
  import z80_exec_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        issue,
  input  logic        use_imm,
  input  alu_op_t     op,
  input  reg_idx_t    dst,
  input  reg_idx_t    src,
  input  logic [7:0]  imm,
  input  logic [7:0]  x_byte,
  input  logic [7:0]  y_byte,
  input  logic [15:0] x_pair,
  input  logic [15:0] y_pair,
  input  logic [15:0] alu_result,
  output reg_idx_t    x_sel,
  output reg_idx_t    y_sel,
  output reg_idx_t    wr_sel,
  output alu_op_t     cur_op,
  output logic [15:0] alu_x,
  output logic [15:0] alu_y,
  output logic [15:0] wr_data,
  output logic        wr_en,
  output logic        wr_wide,
  output logic        flag_upd,
  output logic        done
);

  exec_state_t state;
  reg_idx_t    dst_q;
  reg_idx_t    src_q;
  logic        use_imm_q;
  logic [7:0]  imm_q;
  logic        wide;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= EX_IDLE;
      done  <= 1'b0;
    end else begin
      if (issue) begin
        state <= EX_WRITE;  // Back to back issue stays here
      end else begin
        state <= EX_IDLE;
      end
      done <= (state == EX_WRITE);
    end
  end

  // Operation fields
  always_ff @(posedge clk) begin
    if (issue) begin
      cur_op    <= op;
      dst_q     <= dst;
      src_q     <= src;
      use_imm_q <= use_imm;
      imm_q     <= imm;
    end
  end

  assign wide   = (cur_op == ADD16) || (cur_op == SUB16);
  assign x_sel  = dst_q;
  assign y_sel  = src_q;
  assign wr_sel = dst_q;

  // Pairs for 16-bit ops, zero-extended bytes otherwise
  assign alu_x = wide ? x_pair : {8'h00, x_byte};
  assign alu_y = use_imm_q ? {8'h00, imm_q} : (wide ? y_pair : {8'h00, y_byte});

  assign wr_data  = alu_result;
  assign wr_wide  = wide;
  assign flag_upd = (state == EX_WRITE);
  assign wr_en    = (state == EX_WRITE) && (cur_op != BIT);  // BIT only tests

endmodule

/* source/z80_exec_top.sv */
`timescale 1ns/1ps

module z80_exec_top
  import z80_exec_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       issue,
  input  logic       use_imm,
  input  logic       load,
  input  alu_op_t    op,
  input  reg_idx_t   dst,
  input  reg_idx_t   src,
  input  reg_idx_t   load_sel,
  input  reg_idx_t   rd_sel,
  input  logic [7:0] imm,
  input  logic [7:0] load_data,
  output logic [7:0] rd_data,
  output logic [7:0] flags,
  output logic       done
);

  reg_idx_t    x_sel, y_sel, wr_sel;
  alu_op_t     cur_op;
  logic [7:0]  x_byte, y_byte;
  logic [15:0] x_pair, y_pair;
  logic [15:0] alu_x, alu_y, alu_result, wr_data;
  logic [7:0]  alu_flags;
  logic        wr_en, wr_wide, flag_upd, carry;

  exec_stage u_exec_stage (
    .clk(clk), .rst_n(rst_n), .issue(issue), .use_imm(use_imm),
    .op(op), .dst(dst), .src(src), .imm(imm),
    .x_byte(x_byte), .y_byte(y_byte), .x_pair(x_pair), .y_pair(y_pair),
    .alu_result(alu_result), .x_sel(x_sel), .y_sel(y_sel), .wr_sel(wr_sel),
    .cur_op(cur_op), .alu_x(alu_x), .alu_y(alu_y), .wr_data(wr_data),
    .wr_en(wr_en), .wr_wide(wr_wide), .flag_upd(flag_upd), .done(done)
  );

  alu u_alu (
    .cin(carry), .op(cur_op), .x(alu_x), .y(alu_y),
    .flags(alu_flags), .result(alu_result)
  );

  reg_file u_reg_file (
    .clk(clk), .rst_n(rst_n),
    .x_sel(x_sel), .y_sel(y_sel), .dbg_sel(rd_sel), .wr_sel(wr_sel),
    .load_sel(load_sel), .x_byte(x_byte), .y_byte(y_byte), .dbg_data(rd_data),
    .x_pair(x_pair), .y_pair(y_pair), .wr_en(wr_en), .wr_wide(wr_wide),
    .load(load), .wr_data(wr_data), .load_data(load_data)
  );

  // Carry-in for the ALU comes from here
  flag_reg u_flag_reg (
    .clk(clk), .rst_n(rst_n), .upd(flag_upd), .op(cur_op),
    .alu_flags(alu_flags), .flags(flags), .carry(carry)
  );

endmodule

/* testbench/z80_exec_sva.sv */
`timescale 1ns/1ps

module z80_exec_sva
  import z80_exec_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        issue,
  input logic        done,
  input logic        wr_en,
  input alu_op_t     op,
  input exec_state_t state
);

  int fail_count = 0;  // Read by the testbench at the end

  // Done two edges after a sampled issue, and at no other time
  done_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
    done == $past(issue, 2))
    else begin
      $error("done does not follow issue by one cycle");
      fail_count++;
    end

  // A BIT taken on the previous edge writes no register
  no_write_on_bit: assert property (@(posedge clk) disable iff (!rst_n)
    $past(issue) && $past(op) == BIT |-> !wr_en)
    else begin
      $error("register write-back during BIT");
      fail_count++;
    end

  // Synchronous reset clears the stage at the next edge
  idle_after_reset: assert property (@(posedge clk)
    !rst_n |=> !done && state == EX_IDLE)
    else begin
      $error("stage not idle after reset");
      fail_count++;
    end

endmodule

/* testbench/z80_exec_tb.sv */
`timescale 1ns/1ps

module z80_exec_tb
  import z80_exec_pkg::*;
();

  logic        clk = 1'b0;
  logic        rst_n, issue, use_imm, load, done;
  alu_op_t     op;
  reg_idx_t    dst, src, load_sel, rd_sel;
  logic [7:0]  imm, load_data, rd_data, flags;

  logic [31:0] lfsr = 32'hdb2b_f8f5;
  logic [31:0] rv;
  logic [7:0]  m_regs [8];  // Reference register file
  logic [7:0]  m_flags;
  int          errors = 0;
  int          checks = 0;
  int          test_errors;
  int          done_count;
  int          sva_fails;
  alu_op_t     q_op [50];
  reg_idx_t    q_dst [50];
  reg_idx_t    q_src [50];

  alu_op_t byte_ops [16] = '{ADD8, SUB8, ADC, SBC, AND, OR, XOR, NOT,
                             RR, RL, RRC, RLC, SLA, SRA, SLL, SRL};
  alu_op_t bit_ops [4] = '{RES, SET, BIT, BIT};

  always #4 clk = ~clk;

  z80_exec_top u_z80_exec_top (
    .clk(clk), .rst_n(rst_n), .issue(issue), .use_imm(use_imm), .load(load),
    .op(op), .dst(dst), .src(src), .load_sel(load_sel), .rd_sel(rd_sel),
    .imm(imm), .load_data(load_data), .rd_data(rd_data), .flags(flags), .done(done)
  );

  bind exec_stage z80_exec_sva u_sva (
    .clk(clk), .rst_n(rst_n), .issue(issue), .done(done), .wr_en(wr_en),
    .op(op), .state(state)
  );

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic int sext(input logic [15:0] val, input logic wide);
    return wide ? int'($signed(val)) : int'($signed(val[7:0]));
  endfunction

  task automatic model_op(input alu_op_t o, input reg_idx_t d, input reg_idx_t s,
                          input logic imm_sel, input logic [7:0] imm_val);
    logic [15:0] a, b, r;
    logic [7:0]  f;
    logic [2:0]  dh, sh;
    logic        c, v, cin, wide;
    int          sum, ssum, ci;
    dh   = {d[2:1], 1'b0};
    sh   = {s[2:1], 1'b0};
    wide = (o == ADD16) || (o == SUB16);
    cin  = m_flags[FLAG_C];
    ci   = ((o == ADC) || (o == SBC)) ? int'(cin) : 0;
    a    = wide ? {m_regs[dh], m_regs[dh | 3'd1]} : {8'h00, m_regs[d]};
    b    = wide ? {m_regs[sh], m_regs[sh | 3'd1]} : {8'h00, m_regs[s]};
    if (imm_sel) begin
      b = {8'h00, imm_val};
    end
    c    = 1'b0;
    v    = 1'b0;
    r    = 16'h0000;
    ssum = 0;
    case (o)
      ADD8, ADC, ADD16: begin
        sum  = int'(a) + int'(b) + ci;
        ssum = sext(a, wide) + sext(b, wide) + ci;
        c    = wide ? sum > 65535 : sum > 255;
        r    = sum[15:0];
      end
      SUB8, SBC, SUB16: begin
        sum  = int'(a) - int'(b) - ci;
        ssum = sext(a, wide) - sext(b, wide) - ci;
        c    = sum < 0;  // Borrow
        r    = sum[15:0];
      end
      AND: r[7:0] = a[7:0] & b[7:0];
      OR:  r[7:0] = a[7:0] | b[7:0];
      XOR: r[7:0] = a[7:0] ^ b[7:0];
      NOT: r[7:0] = ~a[7:0];
      RR:  {r[7:0], c} = {cin, a[7:0]};
      RL:  {c, r[7:0]} = {a[7:0], cin};
      RRC: {r[7:0], c} = {a[0], a[7:0]};
      RLC: {c, r[7:0]} = {a[7:0], a[7]};
      SLA: {c, r[7:0]} = {a[7:0], 1'b0};
      SRA: {r[7:0], c} = {a[7], a[7:0]};
      SLL: {c, r[7:0]} = {a[7:0], 1'b1};
      SRL: {r[7:0], c} = {1'b0, a[7:0]};
      RES: r[7:0] = a[7:0] & ~(8'h01 << b[2:0]);
      SET: r[7:0] = a[7:0] | (8'h01 << b[2:0]);
      default: r = 16'h0000;
    endcase
    if (o inside {ADD8, ADC, ADD16, SUB8, SBC, SUB16}) begin
      v = wide ? (ssum > 32767 || ssum < -32768) : (ssum > 127 || ssum < -128);
    end else if (o inside {AND, OR, XOR, SLA, SRA, SLL}) begin
      v = ~^r[7:0];  // Even parity
    end
    f         = 8'h00;
    f[FLAG_S] = wide ? r[15] : r[7];
    f[FLAG_Z] = wide ? (r == 16'h0000) : (r[7:0] == 8'h00);
    f[FLAG_V] = v;
    f[FLAG_N] = (o == ADD8) || (o == ADC) || (o == ADD16);
    f[FLAG_C] = c;
    case (o)
      RES, SET: m_regs[d] = r[7:0];
      BIT:      m_flags[FLAG_Z] = ~a[b[2:0]];
      ADD16, SUB16: begin
        m_regs[dh]         = r[15:8];
        m_regs[dh | 3'd1]  = r[7:0];
        m_flags            = f;
      end
      default: begin
        m_regs[d] = r[7:0];
        m_flags   = f;
      end
    endcase
  endtask

  task automatic check_val(input logic [7:0] got, input logic [7:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: %s read %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic read_reg(input reg_idx_t sel, output logic [7:0] val);
    @(posedge clk);
    rd_sel <= sel;
    @(negedge clk);
    val = rd_data;
  endtask

  task automatic check_all(input string what);
    logic [7:0] val;
    for (int i = 0; i < 8; i++) begin
      read_reg(reg_idx_t'(i[2:0]), val);
      check_val(val, m_regs[i], $sformatf("%s reg %0d", what, i));
    end
    check_val(flags, m_flags, {what, " flags"});
  endtask

  task automatic wait_done(input string what);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!done && n < 20);
    if (!done) begin
      $display("Timeout at %0t ns: done never came after %s", $time, what);
      errors++;
    end
  endtask

  task automatic load_reg(input reg_idx_t sel, input logic [7:0] data);
    @(posedge clk);
    load      <= 1'b1;
    load_sel  <= sel;
    load_data <= data;
    @(posedge clk);
    load      <= 1'b0;
    m_regs[sel] = data;
  endtask

  task automatic issue_op(input alu_op_t o, input reg_idx_t d, input reg_idx_t s,
                          input logic imm_sel, input logic [7:0] imm_val,
                          input logic clash, input logic [7:0] clash_data);
    @(posedge clk);
    issue   <= 1'b1;
    op      <= o;
    dst     <= d;
    src     <= s;
    use_imm <= imm_sel;
    imm     <= imm_val;
    @(posedge clk);
    issue     <= 1'b0;
    load      <= clash;  // Sampled on the write-back edge
    load_sel  <= d;
    load_data <= clash_data;
    @(posedge clk);
    load <= 1'b0;
    wait_done(o.name());
    model_op(o, d, s, imm_sel, imm_val);
  endtask

  task automatic finish_test(input string name);
    $display("Test %-24s %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  initial begin
    rst_n     <= 1'b0;
    issue     <= 1'b0;
    use_imm   <= 1'b0;
    load      <= 1'b0;
    op        <= ADD8;
    dst       <= REG_B;
    src       <= REG_B;
    load_sel  <= REG_B;
    rd_sel    <= REG_B;
    imm       <= 8'h00;
    load_data <= 8'h00;
    for (int i = 0; i < 8; i++) begin
      m_regs[i] = 8'h00;
    end
    m_flags     = 8'h00;
    test_errors = 0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);
    check_val({7'b0, done}, 8'h00, "done after reset");
    check_all("reset");
    finish_test("reset values");

    for (int i = 0; i < 8; i++) begin
      rv = take_bits(8);
      load_reg(reg_idx_t'(i[2:0]), rv[7:0]);
    end
    check_all("load");
    rv = take_bits(16);
    issue_op(ADD8, REG_A, REG_B, 1'b1, rv[7:0], 1'b1, rv[15:8]);
    check_all("load clash");
    finish_test("load and read back");

    for (int n = 0; n < 200; n++) begin
      rv = take_bits(19);
      issue_op(byte_ops[rv[18:15]], reg_idx_t'(rv[14:12]), reg_idx_t'(rv[11:9]),
               rv[8], rv[7:0], 1'b0, 8'h00);
      check_all("byte op");
    end
    finish_test("random 8-bit ops");

    for (int n = 0; n < 40; n++) begin
      rv = take_bits(16);
      issue_op(rv[15] ? SUB16 : ADD16, reg_idx_t'(rv[14:12]), reg_idx_t'(rv[11:9]),
               rv[8], rv[7:0], 1'b0, 8'h00);
      check_all("pair op");
    end
    finish_test("16-bit ops");

    for (int n = 0; n < 40; n++) begin
      rv = take_bits(17);
      issue_op(bit_ops[rv[16:15]], reg_idx_t'(rv[14:12]), reg_idx_t'(rv[11:9]),
               rv[8], rv[7:0], 1'b0, 8'h00);
      check_all("bit op");
    end
    finish_test("RES SET BIT");

    // Each op reads the register the previous one wrote
    for (int n = 0; n < 50; n++) begin
      rv       = take_bits(10);
      q_op[n]  = byte_ops[rv[9:6]];
      q_dst[n] = reg_idx_t'(rv[5:3]);
      q_src[n] = (n == 0) ? reg_idx_t'(rv[2:0]) : q_dst[n - 1];
    end
    done_count = 0;
    for (int n = 0; n < 53; n++) begin
      @(posedge clk);
      issue   <= (n < 50);
      use_imm <= 1'b0;
      if (n < 50) begin
        op  <= q_op[n];
        dst <= q_dst[n];
        src <= q_src[n];
      end
      if (n >= 2 && n < 52) begin
        rd_sel <= q_dst[n - 2];
      end
      @(negedge clk);
      if (done) begin
        done_count++;
      end
      check_val({7'b0, done}, (n >= 2 && n < 52) ? 8'h01 : 8'h00, "done timing");
      if (n >= 2 && n < 52) begin
        model_op(q_op[n - 2], q_dst[n - 2], q_src[n - 2], 1'b0, 8'h00);
        check_val(rd_data, m_regs[q_dst[n - 2]], "chained dst");
        check_val(flags, m_flags, "chained flags");
      end
    end
    check_val(done_count[7:0], 8'd50, "done count");
    check_all("after chain");
    finish_test("back-to-back chain");

    sva_fails = u_z80_exec_top.u_exec_stage.u_sva.fail_count;
    $display("Summary: %0d checks, %0d check errors, %0d assertion failures",
             checks, errors, sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* z80_exec.f */
source/z80_exec_pkg.sv
source/alu.sv
source/reg_file.sv
source/flag_reg.sv
source/exec_stage.sv
source/z80_exec_top.sv
testbench/z80_exec_sva.sv
testbench/z80_exec_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and pass only when the pass message shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f z80_exec.f --top-module z80_exec_tb \
  -o z80_exec_sim || exit 1
out=$(./obj_dir/z80_exec_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "No errors" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
